// File: source/cal_pkg.sv
package cal_pkg;

  // Fixed channel count, the register map is laid out for two
  localparam int unsigned NUM_CH = 2;

  //////////////////////////////
  // Datapath types
  //////////////////////////////

  // Raw ADC word, inverted slope with offset
  typedef logic        [13:0] adc_raw_t;
  // Two's complement sample, acquire and generate side
  typedef logic signed [13:0] sample_t;
  // Code toward the DAC pins
  typedef logic        [13:0] dac_code_t;
  // Fixed point gain, fraction width set by GAIN_FRAC
  typedef logic signed [15:0] gain_t;
  // Offset added after scaling
  typedef logic signed [13:0] offset_t;

  // Saturation limits
  localparam sample_t SMP_MAX = 14'sh1FFF;
  localparam sample_t SMP_MIN = -14'sh2000;

  // Zero sample as a DAC code
  localparam dac_code_t DAC_CODE_ZERO = 14'h1FFF;

  //////////////////////////////
  // Configuration map
  //////////////////////////////

  typedef logic [3:0]  cfg_addr_t;
  typedef logic [15:0] cfg_data_t;

  // 1.0 with 14 fractional bits
  localparam gain_t GAIN_UNITY = 16'sh4000;

  // Base addresses, low bit selects the channel
  localparam cfg_addr_t CFG_ADC_GAIN = 4'd0;
  localparam cfg_addr_t CFG_ADC_OFFS = 4'd2;
  localparam cfg_addr_t CFG_DAC_GAIN = 4'd4;
  localparam cfg_addr_t CFG_DAC_OFFS = 4'd6;
  localparam cfg_addr_t CFG_LOOP     = 4'd8;

endpackage : cal_pkg

// File: source/calib_regs.sv
`timescale 1ns/1ns

module calib_regs import cal_pkg::*; (
  input  logic                     adc_clk,
  input  logic                     top_rst,
  // Register access
  input  logic                     cfg_we_i,
  input  cfg_addr_t                cfg_addr_i,
  input  cfg_data_t                cfg_wdata_i,
  output cfg_data_t                cfg_rdata_o,
  // Calibration settings
  output gain_t   [NUM_CH-1:0]     adc_gain_o,
  output offset_t [NUM_CH-1:0]     adc_offs_o,
  output gain_t   [NUM_CH-1:0]     dac_gain_o,
  output offset_t [NUM_CH-1:0]     dac_offs_o,
  output logic    [NUM_CH-1:0]     loop_en_o
);

  // Zero padding for readback of narrow registers
  localparam int unsigned OFFS_PAD = $bits(cfg_data_t) - $bits(offset_t);
  localparam int unsigned LOOP_PAD = $bits(cfg_data_t) - NUM_CH;

  gain_t   [NUM_CH-1:0] adc_gain_q;
  offset_t [NUM_CH-1:0] adc_offs_q;
  gain_t   [NUM_CH-1:0] dac_gain_q;
  offset_t [NUM_CH-1:0] dac_offs_q;
  logic    [NUM_CH-1:0] loop_q;

  // Address split into register pair and channel
  cfg_addr_t cfg_base;
  logic      cfg_ch;

  assign cfg_base = {cfg_addr_i[3:1], 1'b0};
  assign cfg_ch   = cfg_addr_i[0];

  //////////////////////////////
  // Write side
  //////////////////////////////

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      adc_gain_q <= {NUM_CH{GAIN_UNITY}};
      adc_offs_q <= '0;
      dac_gain_q <= {NUM_CH{GAIN_UNITY}};
      dac_offs_q <= '0;
      loop_q     <= '0;
    end else if (cfg_we_i) begin
      case (cfg_base)
        CFG_ADC_GAIN: adc_gain_q[cfg_ch] <= cfg_wdata_i;
        CFG_ADC_OFFS: adc_offs_q[cfg_ch] <= cfg_wdata_i[$bits(offset_t)-1:0];
        CFG_DAC_GAIN: dac_gain_q[cfg_ch] <= cfg_wdata_i;
        CFG_DAC_OFFS: dac_offs_q[cfg_ch] <= cfg_wdata_i[$bits(offset_t)-1:0];
        CFG_LOOP: begin
          // Only address 8 is mapped, 9 is a hole
          if (!cfg_ch) begin
            loop_q <= cfg_wdata_i[NUM_CH-1:0];
          end
        end
        default: ;
      endcase
    end
  end

  //////////////////////////////
  // Readback
  //////////////////////////////

  always_comb begin
    cfg_rdata_o = '0;
    case (cfg_base)
      CFG_ADC_GAIN: cfg_rdata_o = adc_gain_q[cfg_ch];
      CFG_ADC_OFFS: cfg_rdata_o = {{OFFS_PAD{1'b0}}, adc_offs_q[cfg_ch]};
      CFG_DAC_GAIN: cfg_rdata_o = dac_gain_q[cfg_ch];
      CFG_DAC_OFFS: cfg_rdata_o = {{OFFS_PAD{1'b0}}, dac_offs_q[cfg_ch]};
      CFG_LOOP: begin
        if (!cfg_ch) begin
          cfg_rdata_o = {{LOOP_PAD{1'b0}}, loop_q};
        end
      end
      default: cfg_rdata_o = '0;
    endcase
  end

  // Settings toward both datapaths
  assign adc_gain_o = adc_gain_q;
  assign adc_offs_o = adc_offs_q;
  assign dac_gain_o = dac_gain_q;
  assign dac_offs_o = dac_offs_q;
  assign loop_en_o  = loop_q;

endmodule : calib_regs

// File: source/linear_scaler.sv
`timescale 1ns/1ns

module linear_scaler import cal_pkg::*; #(
  // Fractional bits of the gain
  parameter int unsigned GAIN_FRAC = 14
) (
  input  logic    adc_clk,
  input  logic    top_rst,
  input  sample_t smp_i,
  input  gain_t   gain_i,
  input  offset_t offs_i,
  output sample_t smp_o
);

  // Full product width
  localparam int unsigned PW = $bits(sample_t) + $bits(gain_t);

  logic signed [PW-1:0] prod_q;
  logic signed [PW-1:0] prod_sh;
  // One extra bit so the offset add cannot wrap
  logic signed [PW:0]   sum_w;
  sample_t              sat_w;
  sample_t              smp_q;

  //////////////////////////////
  // Stage 1, multiply
  //////////////////////////////

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      prod_q <= '0;
    end else begin
      prod_q <= smp_i * gain_i;
    end
  end

  //////////////////////////////
  // Stage 2, scale and offset
  //////////////////////////////

  // Arithmetic shift keeps the sign
  assign prod_sh = prod_q >>> GAIN_FRAC;
  assign sum_w   = prod_sh + offs_i;

  // Clamp to the sample range
  always_comb begin
    if (sum_w > SMP_MAX) begin
      sat_w = SMP_MAX;
    end else if (sum_w < SMP_MIN) begin
      sat_w = SMP_MIN;
    end else begin
      sat_w = sum_w[$bits(sample_t)-1:0];
    end
  end

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      smp_q <= '0;
    end else begin
      smp_q <= sat_w;
    end
  end

  assign smp_o = smp_q;

endmodule : linear_scaler

// File: source/adc_frontend.sv
`timescale 1ns/1ns

module adc_frontend import cal_pkg::*; #(
  parameter int unsigned GAIN_FRAC = 14
) (
  input  logic                     adc_clk,
  input  logic                     top_rst,
  // ADC pins
  input  adc_raw_t [NUM_CH-1:0]    adc_dat_i,
  // Calibrated generator samples for loopback
  input  sample_t  [NUM_CH-1:0]    dac_cal_i,
  input  logic     [NUM_CH-1:0]    loop_en_i,
  // Acquisition calibration
  input  gain_t    [NUM_CH-1:0]    gain_i,
  input  offset_t  [NUM_CH-1:0]    offs_i,
  // Calibrated acquisition samples
  output sample_t  [NUM_CH-1:0]    acq_dat_o
);

  localparam int unsigned SW = $bits(sample_t);

  sample_t [NUM_CH-1:0] adc_smp_q;
  sample_t [NUM_CH-1:0] scl_in;

  //////////////////////////////
  // ADC input registers
  //////////////////////////////

  // Keep MSB, invert the rest for offset to two's complement
  // and to undo the negative slope
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      adc_smp_q <= '0;
    end else begin
      for (int ch = 0; ch < NUM_CH; ch++) begin
        adc_smp_q[ch] <= {adc_dat_i[ch][SW-1], ~adc_dat_i[ch][SW-2:0]};
      end
    end
  end

  //////////////////////////////
  // Loopback and calibration
  //////////////////////////////

  for (genvar ch = 0; ch < NUM_CH; ch++) begin : g_ch

    // Loopback select in front of the scaler
    assign scl_in[ch] = loop_en_i[ch] ? dac_cal_i[ch] : adc_smp_q[ch];

    linear_scaler #(
      .GAIN_FRAC (GAIN_FRAC)
    ) u_scaler (
      .adc_clk (adc_clk),
      .top_rst (top_rst),
      .smp_i   (scl_in[ch]),
      .gain_i  (gain_i[ch]),
      .offs_i  (offs_i[ch]),
      .smp_o   (acq_dat_o[ch])
    );

  end : g_ch

endmodule : adc_frontend

// File: source/dac_backend.sv
`timescale 1ns/1ns

module dac_backend import cal_pkg::*; #(
  parameter int unsigned GAIN_FRAC = 14
) (
  input  logic                      adc_clk,
  input  logic                      top_rst,
  // Generator samples
  input  sample_t   [NUM_CH-1:0]    gen_dat_i,
  input  logic      [NUM_CH-1:0]    gen_vld_i,
  // Generation calibration
  input  gain_t     [NUM_CH-1:0]    gain_i,
  input  offset_t   [NUM_CH-1:0]    offs_i,
  // Calibrated samples, also the loopback source
  output sample_t   [NUM_CH-1:0]    dac_cal_o,
  // DAC codes
  output dac_code_t [NUM_CH-1:0]    dac_dat_o
);

  localparam int unsigned SW = $bits(sample_t);

  sample_t   [NUM_CH-1:0] gen_smp;
  sample_t   [NUM_CH-1:0] cal_smp;
  dac_code_t [NUM_CH-1:0] dac_code_q;

  //////////////////////////////
  // Gating and calibration
  //////////////////////////////

  for (genvar ch = 0; ch < NUM_CH; ch++) begin : g_ch

    // Missing valid counts as a zero sample
    assign gen_smp[ch] = gen_vld_i[ch] ? gen_dat_i[ch] : '0;

    linear_scaler #(
      .GAIN_FRAC (GAIN_FRAC)
    ) u_scaler (
      .adc_clk (adc_clk),
      .top_rst (top_rst),
      .smp_i   (gen_smp[ch]),
      .gain_i  (gain_i[ch]),
      .offs_i  (offs_i[ch]),
      .smp_o   (cal_smp[ch])
    );

  end : g_ch

  //////////////////////////////
  // DAC output registers
  //////////////////////////////

  // Two's complement back to inverted offset code
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      dac_code_q <= {NUM_CH{DAC_CODE_ZERO}};
    end else begin
      for (int ch = 0; ch < NUM_CH; ch++) begin
        dac_code_q[ch] <= {cal_smp[ch][SW-1], ~cal_smp[ch][SW-2:0]};
      end
    end
  end

  assign dac_cal_o = cal_smp;
  assign dac_dat_o = dac_code_q;

endmodule : dac_backend

// File: source/cal_top.sv
`timescale 1ns/1ns

module cal_top import cal_pkg::*; #(
  parameter int unsigned GAIN_FRAC = 14
) (
  input  logic                      adc_clk,
  input  logic                      top_rst,
  // ADC pins
  input  adc_raw_t  [NUM_CH-1:0]    adc_dat_i,
  // Generator samples
  input  sample_t   [NUM_CH-1:0]    gen_dat_i,
  input  logic      [NUM_CH-1:0]    gen_vld_i,
  // Configuration port
  input  logic                      cfg_we_i,
  input  cfg_addr_t                 cfg_addr_i,
  input  cfg_data_t                 cfg_wdata_i,
  output cfg_data_t                 cfg_rdata_o,
  // Calibrated acquisition samples
  output sample_t   [NUM_CH-1:0]    acq_dat_o,
  // DAC codes
  output dac_code_t [NUM_CH-1:0]    dac_dat_o
);

  // Settings from the register block
  gain_t   [NUM_CH-1:0] adc_gain;
  offset_t [NUM_CH-1:0] adc_offs;
  gain_t   [NUM_CH-1:0] dac_gain;
  offset_t [NUM_CH-1:0] dac_offs;
  logic    [NUM_CH-1:0] loop_en;
  // Loopback path, generate side to acquire side
  sample_t [NUM_CH-1:0] dac_cal;

  //////////////////////////////
  // Configuration registers
  //////////////////////////////

  calib_regs u_regs (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_rdata_o (cfg_rdata_o),
    .adc_gain_o  (adc_gain),
    .adc_offs_o  (adc_offs),
    .dac_gain_o  (dac_gain),
    .dac_offs_o  (dac_offs),
    .loop_en_o   (loop_en)
  );

  //////////////////////////////
  // Acquire and generate paths
  //////////////////////////////

  adc_frontend #(
    .GAIN_FRAC (GAIN_FRAC)
  ) u_adc (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .adc_dat_i (adc_dat_i),
    .dac_cal_i (dac_cal),
    .loop_en_i (loop_en),
    .gain_i    (adc_gain),
    .offs_i    (adc_offs),
    .acq_dat_o (acq_dat_o)
  );

  dac_backend #(
    .GAIN_FRAC (GAIN_FRAC)
  ) u_dac (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .gen_dat_i (gen_dat_i),
    .gen_vld_i (gen_vld_i),
    .gain_i    (dac_gain),
    .offs_i    (dac_offs),
    .dac_cal_o (dac_cal),
    .dac_dat_o (dac_dat_o)
  );

endmodule : cal_top

// File: verification/tb_cal_checks.svh
`ifndef TB_CAL_CHECKS_SVH
`define TB_CAL_CHECKS_SVH

// Number of compares done so far
int n_checks = 0;

//////////////////////////////
// Reference model
//////////////////////////////

// ADC word to sample, MSB kept and the lower 13 bits inverted
function automatic sample_t adc_to_sample(input adc_raw_t raw);
  return sample_t'(raw ^ 14'h1FFF);
endfunction

// Sample back to DAC code, same bit rule
function automatic dac_code_t sample_to_code(input sample_t smp);
  return dac_code_t'(smp) ^ 14'h1FFF;
endfunction

// Gain, arithmetic shift by the fraction width, offset, clamp
function automatic sample_t scale_sample(input sample_t smp, input gain_t gain,
                                         input offset_t offs, input int frac);
  longint sum;
  sum = ((longint'(smp) * longint'(gain)) >>> frac) + longint'(offs);
  if (sum > 8191) begin
    return sample_t'(8191);
  end
  if (sum < -8192) begin
    return sample_t'(-8192);
  end
  return sample_t'(sum);
endfunction

// Bits a register keeps; holes keep nothing
function automatic cfg_data_t reg_mask(input int addr);
  case (addr)
    0, 1, 4, 5: return 16'hFFFF;
    2, 3, 6, 7: return 16'h3FFF;
    8:          return 16'h0003;
    default:    return 16'h0000;
  endcase
endfunction

//////////////////////////////
// Compare tasks
//////////////////////////////

task automatic check_sample(input string name, input sample_t exp, input sample_t act);
  n_checks++;
  if (act !== exp) begin
    $display("** Error %s: expected %0d, actual %0d", name, exp, act);
    $display("TEST FAILED");
    $fatal(1, "sample mismatch");
  end
endtask

task automatic check_code(input string name, input dac_code_t exp, input dac_code_t act);
  n_checks++;
  if (act !== exp) begin
    $display("** Error %s: expected 0x%04h, actual 0x%04h", name, exp, act);
    $display("TEST FAILED");
    $fatal(1, "DAC code mismatch");
  end
endtask

task automatic check_cfg(input string name, input cfg_data_t exp, input cfg_data_t act);
  n_checks++;
  if (act !== exp) begin
    $display("** Error %s: expected 0x%04h, actual 0x%04h", name, exp, act);
    $display("TEST FAILED");
    $fatal(1, "readback mismatch");
  end
endtask

`endif

// File: verification/tb_cal_top.sv
`timescale 1ns/1ns

module tb_cal_top import cal_pkg::*; ();

  localparam int GAIN_FRAC  = 14;
  localparam int MAX_CYCLES = 20000;
  // Cycles from the drive edge to the checked output
  localparam int ACQ_DEPTH  = 3;
  localparam int CODE_DEPTH = 3;
  localparam int LOOP_DEPTH = 4;

  typedef sample_t   [NUM_CH-1:0] smp_vec_t;
  typedef dac_code_t [NUM_CH-1:0] code_vec_t;

  logic                   adc_clk = 1'b0;
  logic                   top_rst;
  adc_raw_t [NUM_CH-1:0]  adc_dat;
  smp_vec_t               gen_dat;
  logic     [NUM_CH-1:0]  gen_vld;
  logic                   cfg_we;
  cfg_addr_t              cfg_addr;
  cfg_data_t              cfg_wdata;
  cfg_data_t              cfg_rdata;
  smp_vec_t               acq_dat;
  code_vec_t              dac_dat;

  // Configuration as the model sees it
  gain_t               adc_gain_m [NUM_CH];
  offset_t             adc_offs_m [NUM_CH];
  gain_t               dac_gain_m [NUM_CH];
  offset_t             dac_offs_m [NUM_CH];
  logic   [NUM_CH-1:0] loop_m;

  integer seed = 32'h52d41c65;

  // Expected results in drive order
  smp_vec_t  acq_q[$];
  smp_vec_t  loop_q[$];
  code_vec_t code_q[$];

  `include "tb_cal_checks.svh"

  cal_top #(
    .GAIN_FRAC (GAIN_FRAC)
  ) dut0 (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .adc_dat_i   (adc_dat),
    .gen_dat_i   (gen_dat),
    .gen_vld_i   (gen_vld),
    .cfg_we_i    (cfg_we),
    .cfg_addr_i  (cfg_addr),
    .cfg_wdata_i (cfg_wdata),
    .cfg_rdata_o (cfg_rdata),
    .acq_dat_o   (acq_dat),
    .dac_dat_o   (dac_dat)
  );

  // 20 ns period
  always #10 adc_clk = ~adc_clk;

  //////////////////////////////
  // Bus and timing helpers
  //////////////////////////////

  task automatic idle_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge adc_clk);
      #2;
    end
  endtask

  task automatic cfg_write(input cfg_addr_t addr, input cfg_data_t data);
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    @(posedge adc_clk);
    #2;
    cfg_we = 1'b0;
  endtask

  // Readback is combinational, short settle only
  task automatic cfg_read(input string name, input int addr, input cfg_data_t exp);
    cfg_addr = cfg_addr_t'(addr);
    #1;
    check_cfg($sformatf("%s addr %0d", name, addr), exp, cfg_rdata);
  endtask

  //////////////////////////////
  // Configuration phases
  //////////////////////////////

  task automatic random_config(input logic [NUM_CH-1:0] loop);
    for (int ch = 0; ch < NUM_CH; ch++) begin
      adc_gain_m[ch] = $random(seed);
      adc_offs_m[ch] = $random(seed);
      dac_gain_m[ch] = $random(seed);
      dac_offs_m[ch] = $random(seed);
    end
    loop_m = loop;
  endtask

  // Write the model config, settle, drop stale expectations
  task automatic apply_config();
    for (int ch = 0; ch < NUM_CH; ch++) begin
      cfg_write(cfg_addr_t'(CFG_ADC_GAIN + ch), adc_gain_m[ch]);
      cfg_write(cfg_addr_t'(CFG_ADC_OFFS + ch), cfg_data_t'(adc_offs_m[ch]));
      cfg_write(cfg_addr_t'(CFG_DAC_GAIN + ch), dac_gain_m[ch]);
      cfg_write(cfg_addr_t'(CFG_DAC_OFFS + ch), cfg_data_t'(dac_offs_m[ch]));
    end
    cfg_write(CFG_LOOP, {14'b0, loop_m});
    idle_cycles(6);
    acq_q.delete();
    loop_q.delete();
    code_q.delete();
  endtask

  //////////////////////////////
  // Random traffic and scoreboard
  //////////////////////////////

  task automatic run_traffic(input string name, input int cycles);
    smp_vec_t  exp_acq;
    smp_vec_t  exp_loop;
    code_vec_t exp_code;
    sample_t   cal;
    for (int i = 0; i < cycles; i++) begin
      @(posedge adc_clk);
      #2;
      // Outputs are stable here
      for (int ch = 0; ch < NUM_CH; ch++) begin
        if (code_q.size() == CODE_DEPTH) begin
          check_code($sformatf("%s ch%0d dac", name, ch), code_q[0][ch], dac_dat[ch]);
        end
        if (loop_m[ch] && loop_q.size() == LOOP_DEPTH) begin
          check_sample($sformatf("%s ch%0d loop", name, ch), loop_q[0][ch], acq_dat[ch]);
        end else if (!loop_m[ch] && acq_q.size() == ACQ_DEPTH) begin
          check_sample($sformatf("%s ch%0d acq", name, ch), acq_q[0][ch], acq_dat[ch]);
        end
      end
      // Next inputs and what they should produce
      for (int ch = 0; ch < NUM_CH; ch++) begin
        adc_dat[ch] = $random(seed);
        gen_dat[ch] = $random(seed);
        gen_vld[ch] = $random(seed);
        cal = scale_sample(gen_vld[ch] ? gen_dat[ch] : sample_t'(0),
                           dac_gain_m[ch], dac_offs_m[ch], GAIN_FRAC);
        exp_code[ch] = sample_to_code(cal);
        exp_loop[ch] = scale_sample(cal, adc_gain_m[ch], adc_offs_m[ch], GAIN_FRAC);
        exp_acq[ch]  = scale_sample(adc_to_sample(adc_dat[ch]), adc_gain_m[ch],
                                    adc_offs_m[ch], GAIN_FRAC);
      end
      code_q.push_back(exp_code);
      loop_q.push_back(exp_loop);
      acq_q.push_back(exp_acq);
      if (code_q.size() > CODE_DEPTH) void'(code_q.pop_front());
      if (loop_q.size() > LOOP_DEPTH) void'(loop_q.pop_front());
      if (acq_q.size() > ACQ_DEPTH) void'(acq_q.pop_front());
    end
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    cfg_data_t reg_m [16];
    cfg_data_t wdata;
    // 14'h1FFF on the ADC pins is a zero sample
    top_rst   = 1'b1;
    adc_dat   = {NUM_CH{14'h1FFF}};
    gen_dat   = '0;
    gen_vld   = '0;
    cfg_we    = 1'b0;
    cfg_addr  = '0;
    cfg_wdata = '0;
    loop_m    = '0;
    repeat (16) @(posedge adc_clk);
    #2;
    top_rst = 1'b0;
    // Pipeline registers still hold their reset values
    for (int ch = 0; ch < NUM_CH; ch++) begin
      check_sample("reset acq", sample_t'(0), acq_dat[ch]);
      check_code("reset dac", dac_code_t'(14'h1FFF), dac_dat[ch]);
    end

    // Register reset values, then masked random writes
    for (int a = 0; a < 16; a++) begin
      cfg_read("reset regs", a, (a inside {0, 1, 4, 5}) ? 16'h4000 : 16'h0000);
    end
    for (int a = 0; a < 16; a++) begin
      wdata = $random(seed);
      cfg_write(cfg_addr_t'(a), wdata);
      reg_m[a] = wdata & reg_mask(a);
    end
    for (int a = 0; a < 16; a++) begin
      cfg_read("regs", a, reg_m[a]);
    end

    // Unity gain on both sides
    for (int ch = 0; ch < NUM_CH; ch++) begin
      adc_gain_m[ch] = 16'sh4000;
      adc_offs_m[ch] = '0;
      dac_gain_m[ch] = 16'sh4000;
      dac_offs_m[ch] = '0;
    end
    loop_m = '0;
    apply_config();
    run_traffic("adc_unity", 200);

    // Full range gains saturate often
    repeat (4) begin
      random_config(2'b00);
      apply_config();
      run_traffic("adc_cal", 150);
    end
    repeat (2) begin
      random_config(2'b00);
      apply_config();
      run_traffic("gen", 150);
    end

    // One loop bit, then the other, then both
    for (int lp = 1; lp < 4; lp++) begin
      random_config(lp[NUM_CH-1:0]);
      apply_config();
      run_traffic($sformatf("loop %0d", lp), 150);
    end

    if (n_checks > 0) begin
      $display("TEST OK");
      $finish;
    end else begin
      $display("No compare was executed");
      $display("TEST FAILED");
      $fatal(1, "empty run");
    end
  end

  // Overall cycle limit
  initial begin
    repeat (MAX_CYCLES) @(posedge adc_clk);
    $display("Simulation did not finish within %0d clock cycles", MAX_CYCLES);
    $display("TEST FAILED");
    $fatal(1, "cycle limit");
  end

endmodule : tb_cal_top

// File: files.f
+incdir+verification
source/cal_pkg.sv
source/calib_regs.sv
source/linear_scaler.sv
source/adc_frontend.sv
source/dac_backend.sv
source/cal_top.sv
verification/tb_cal_top.sv
